/* project.f */
verilog/hps_cfg_pkg.sv
verilog/io_cmd_decoder.sv
verilog/reconfig_fifo.sv
verilog/pll_cfg_writer.sv
verilog/hps_cfg_top.sv
tests/cfg_checker.sv
tests/tb_hps_cfg.sv

/* Makefile */
SIM      = verilator
TOP      = tb_hps_cfg
FILELIST = project.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_hps_cfg.sv */
`timescale 1ns/1ps

module tb_hps_cfg;

	localparam int n_rows = 77;
	localparam int timeout_cycles = n_rows * 40 + 200;
	localparam int tw = hps_cfg_pkg::timing_width;

	logic FPGA_CLK2_50 = 1'b0;
	logic resetd = 1'b1;
	logic io_clk = 1'b0;
	logic io_uio = 1'b0;
	logic [hps_cfg_pkg::io_width-1:0] io_din = '0;
	logic mgmt_waitrequest = 1'b1;
	logic io_ack, dvi_mode, audio_96k, ypbpr_en, csync;
	logic [tw-1:0] width, hfp, hs, hbp, height, vfp, vs, vbp;
	logic mgmt_write, cfg_ready;
	logic [hps_cfg_pkg::reg_addr_width-1:0] mgmt_address;
	logic [hps_cfg_pkg::reg_data_width-1:0] mgmt_writedata;
	int seed = 18585;
	int cycles = 0;
	int cur_test = 1;

	// ====================
	// Stimulus table
	// ====================
	// Row: test, io_uio, effect, host word
	// Effect 1 closes a custom triple, 2 is the first config word, 3 a later one
	logic [27:0] rows [0:n_rows-1] = '{
		28'h1_0_0_0000,
		28'h2_1_0_0020, 28'h2_1_0_F320, 28'h2_1_0_0028, 28'h2_1_0_0080, 28'h2_1_0_0058,
		28'h2_1_0_0258, 28'h2_1_0_0001, 28'h2_1_0_0004, 28'h2_1_0_0017,
		28'h3_1_0_0012, 28'h3_1_0_5678, 28'h3_1_1_1234,
		28'h3_1_0_00C4, 28'h3_1_0_BEEF, 28'h3_1_1_DEAD,
		28'h3_0_0_0000, 28'h3_1_0_0001, 28'h3_1_3_0048,
		28'h4_1_0_0001, 28'h4_1_2_00A8,
		28'h5_0_0_0000, 28'h5_1_0_0020,
		28'h5_1_0_0280, 28'h5_1_0_0010, 28'h5_1_0_0060, 28'h5_1_0_0030,
		28'h5_1_0_01E0, 28'h5_1_0_000A, 28'h5_1_0_0002, 28'h5_1_0_0021,
		28'h5_1_0_FF20, 28'h5_1_0_1000, 28'h5_1_1_A500,
		28'h5_1_0_FF21, 28'h5_1_0_1111, 28'h5_1_1_A501,
		28'h5_1_0_FF22, 28'h5_1_0_2222, 28'h5_1_1_A502,
		28'h5_1_0_FF23, 28'h5_1_0_3333, 28'h5_1_1_A503,
		28'h5_1_0_FF24, 28'h5_1_0_4444, 28'h5_1_1_A504,
		28'h5_1_0_FF25, 28'h5_1_0_5555, 28'h5_1_1_A505,
		28'h5_1_0_FF26, 28'h5_1_0_6666, 28'h5_1_1_A506,
		28'h5_1_0_FF27, 28'h5_1_0_7777, 28'h5_1_1_A507,
		28'h5_1_0_FF28, 28'h5_1_0_8888, 28'h5_1_1_A508,
		28'h5_1_0_FF29, 28'h5_1_0_9999, 28'h5_1_1_A509,
		28'h5_1_0_FF2A, 28'h5_1_0_AAAA, 28'h5_1_1_A50A,
		28'h5_1_0_FF2B, 28'h5_1_0_BBBB, 28'h5_1_1_A50B,
		28'h6_0_0_0000, 28'h6_1_0_0020, 28'h6_1_0_0111, 28'h6_1_0_0222,
		28'h6_0_0_0000, 28'h6_1_0_0020,
		28'h6_1_0_0780, 28'h6_1_0_0058, 28'h6_1_0_002C, 28'h6_1_0_0094
	};

	// Timing at test end: width, hfp, hs, hbp, height, vfp, vs, vbp
	logic [8*tw-1:0] exp_timing [1:6] = '{
		96'h500_06E_028_0DC_2D0_005_005_014,
		96'h320_028_080_058_258_001_004_017,
		96'h320_028_080_058_258_001_004_017,
		96'h500_06E_028_0DC_2D0_005_005_014,
		96'h280_010_060_030_1E0_00A_002_021,
		96'h780_058_02C_094_1E0_00A_002_021
	};

	// Reset first, cfg_ready, dvi_mode, audio_96k, ypbpr_en, csync
	logic [5:0] exp_mode [1:6] = '{6'b000000, 6'b000000, 6'b010101, 6'b111011, 6'b011011,
		6'b011011};

	hps_cfg_top hps_cfg_top_inst (.*);

	cfg_checker cfg_checker_inst (.*);

	always #10 FPGA_CLK2_50 = ~FPGA_CLK2_50;

	// Long stalls in test 5 so the queue fills
	always @(posedge FPGA_CLK2_50) begin
		#2;
		if (cur_test == 5)
			mgmt_waitrequest = ($random(seed) & 63) != 0;
		else
			mgmt_waitrequest = ($random(seed) & 1) != 0;
	end

	always @(posedge FPGA_CLK2_50) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			$display("timeout after %0d cycles in test %0d, %0d writes never arrived",
				cycles, cur_test, cfg_checker_inst.pending);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic apply_reset();
		io_clk = 1'b0;
		io_uio = 1'b0;
		resetd = 1'b1;
		repeat (10) @(posedge FPGA_CLK2_50);
		#2;
		resetd = 1'b0;
	endtask

	// One host word, held until io_ack catches up with io_clk
	task automatic send_word(input logic uio, input logic [15:0] word);
		io_uio = uio;
		io_din = word;
		io_clk = ~io_clk;
		do begin
			@(posedge FPGA_CLK2_50);
			#2;
		end while (io_ack != io_clk);
	endtask

	task automatic finish_test(input int t);
		while (cfg_checker_inst.pending != 0)
			@(posedge FPGA_CLK2_50);
		repeat (3) @(posedge FPGA_CLK2_50);
		#2;
		cfg_checker_inst.check_state(t, exp_timing[t], exp_mode[t][3:0], exp_mode[t][4]);
	endtask

	initial begin
		logic [27:0] row;
		logic [15:0] w1;
		logic [15:0] w2;
		int t;
		w1 = '0;
		w2 = '0;
		apply_reset();
		for (int i = 0; i < n_rows; i++) begin
			row = rows[i];
			t = int'(row[27:24]);
			if (t != cur_test) begin
				finish_test(cur_test);
				cur_test = t;
				if (exp_mode[t][5])
					apply_reset();
			end
			// Address from the first word of a triple, data is high then low
			case (row[19:16])
				4'd1: cfg_checker_inst.expect_write(w2[5:0], {row[15:0], w1});
				4'd2: begin
					cfg_checker_inst.expect_write(6'd31, 32'd0);
					cfg_checker_inst.expect_write(6'd2, 32'd0);
				end
				4'd3: cfg_checker_inst.expect_write(6'd2, 32'd0);
				default: ;
			endcase
			send_word(row[20], row[15:0]);
			w2 = w1;
			w1 = row[15:0];
		end
		finish_test(cur_test);
		cfg_checker_inst.print_summary();
		if (cfg_checker_inst.errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* tests/cfg_checker.sv */
`timescale 1ns/1ps

module cfg_checker (
	input  logic                                   FPGA_CLK2_50,
	input  logic                                   resetd,
	input  logic                                   mgmt_write,
	input  logic                                   mgmt_waitrequest,
	input  logic [hps_cfg_pkg::reg_addr_width-1:0] mgmt_address,
	input  logic [hps_cfg_pkg::reg_data_width-1:0] mgmt_writedata,
	input  logic                                   cfg_ready,
	input  logic                                   dvi_mode, audio_96k, ypbpr_en, csync,
	input  logic [hps_cfg_pkg::timing_width-1:0]   width, hfp, hs, hbp,
	input  logic [hps_cfg_pkg::timing_width-1:0]   height, vfp, vs, vbp
);

	localparam int tw = hps_cfg_pkg::timing_width;

	hps_cfg_pkg::reconfig_write_t exp_q [$];
	int pending = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_base = 0;
	int test_now = 1;
	logic start_accepted = 1'b0;
	logic [8*tw-1:0] timing_now;
	string timing_names [0:7] = '{"width", "hfp", "hs", "hbp", "height", "vfp", "vs", "vbp"};

	assign timing_now = {width, hfp, hs, hbp, height, vfp, vs, vbp};

	task automatic expect_write(input logic [5:0] addr, input logic [31:0] data);
		hps_cfg_pkg::reconfig_write_t w;
		w.addr = addr;
		w.data = data;
		exp_q.push_back(w);
		pending = exp_q.size();
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] test %0d %s: expected 0x%h, got 0x%h", test_now, name, exp, got);
		end
	endtask

	// ====================
	// Accepted writes
	// ====================
	always @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			start_accepted = 1'b0;
		end else begin
			// cfg_ready follows an accepted start write by one cycle
			compare("cfg_ready", 32'(cfg_ready), 32'(start_accepted));
			if (mgmt_write && !mgmt_waitrequest) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("test %0d: write to register %0d arrived but none was expected",
						test_now, mgmt_address);
				end else begin
					compare("mgmt_address", 32'(mgmt_address), 32'(exp_q[0].addr));
					compare("mgmt_writedata", mgmt_writedata, exp_q[0].data);
					if (exp_q[0].addr == hps_cfg_pkg::reg_start)
						start_accepted = 1'b1;
					void'(exp_q.pop_front());
					pending = exp_q.size();
				end
			end
		end
	end

	// End of test state
	task automatic check_state(input int test_no, input logic [8*tw-1:0] exp_timing,
			input logic [3:0] exp_flags, input logic exp_ready);
		for (int i = 0; i < 8; i++)
			compare(timing_names[i], 32'(timing_now[(7-i)*tw +: tw]),
				32'(exp_timing[(7-i)*tw +: tw]));
		compare("dvi_mode", 32'(dvi_mode), 32'(exp_flags[3]));
		compare("audio_96k", 32'(audio_96k), 32'(exp_flags[2]));
		compare("ypbpr_en", 32'(ypbpr_en), 32'(exp_flags[1]));
		compare("csync", 32'(csync), 32'(exp_flags[0]));
		compare("cfg_ready", 32'(cfg_ready), 32'(exp_ready));
		compare("mgmt_write", 32'(mgmt_write), 32'd0);
		tests_run++;
		if (errors == test_base) begin
			$display("test %0d passed", test_no);
		end else begin
			tests_failed++;
			$display("test %0d failed with %0d errors", test_no, errors - test_base);
		end
		test_base = errors;
		test_now = test_no + 1;
	endtask

	task automatic print_summary();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
	endtask

endmodule

/* verilog/hps_cfg_top.sv */
`timescale 1ns/1ps

module hps_cfg_top (
	input  logic                                      FPGA_CLK2_50,
	input  logic                                      resetd,
	// Host link
	input  logic                                      io_clk,
	input  logic                                      io_uio,
	input  logic [hps_cfg_pkg::io_width-1:0]          io_din,
	output logic                                      io_ack,
	// Mode flags
	output logic                                      dvi_mode,
	output logic                                      audio_96k,
	output logic                                      ypbpr_en,
	output logic                                      csync,
	// Video timing
	output logic [hps_cfg_pkg::timing_width-1:0]      width,
	output logic [hps_cfg_pkg::timing_width-1:0]      hfp,
	output logic [hps_cfg_pkg::timing_width-1:0]      hs,
	output logic [hps_cfg_pkg::timing_width-1:0]      hbp,
	output logic [hps_cfg_pkg::timing_width-1:0]      height,
	output logic [hps_cfg_pkg::timing_width-1:0]      vfp,
	output logic [hps_cfg_pkg::timing_width-1:0]      vs,
	output logic [hps_cfg_pkg::timing_width-1:0]      vbp,
	// PLL reconfiguration master
	input  logic                                      mgmt_waitrequest,
	output logic                                      mgmt_write,
	output logic [hps_cfg_pkg::reg_addr_width-1:0]    mgmt_address,
	output logic [hps_cfg_pkg::reg_data_width-1:0]    mgmt_writedata,
	output logic                                      cfg_ready
);

	logic                         push;
	logic                         pop;
	logic                         full;
	logic                         empty;
	hps_cfg_pkg::reconfig_write_t push_data;
	hps_cfg_pkg::reconfig_write_t pop_data;

	io_cmd_decoder io_cmd_decoder_inst (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.io_clk       (io_clk),
		.io_uio       (io_uio),
		.io_din       (io_din),
		.full         (full),
		.io_ack       (io_ack),
		.push         (push),
		.push_data    (push_data),
		.dvi_mode     (dvi_mode),
		.audio_96k    (audio_96k),
		.ypbpr_en     (ypbpr_en),
		.csync        (csync),
		.width        (width),
		.hfp          (hfp),
		.hs           (hs),
		.hbp          (hbp),
		.height       (height),
		.vfp          (vfp),
		.vs           (vs),
		.vbp          (vbp)
	);

	reconfig_fifo reconfig_fifo_inst (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.push         (push),
		.push_data    (push_data),
		.pop          (pop),
		.pop_data     (pop_data),
		.full         (full),
		.empty        (empty)
	);

	pll_cfg_writer pll_cfg_writer_inst (
		.FPGA_CLK2_50     (FPGA_CLK2_50),
		.resetd           (resetd),
		.empty            (empty),
		.pop_data         (pop_data),
		.mgmt_waitrequest (mgmt_waitrequest),
		.pop              (pop),
		.mgmt_write       (mgmt_write),
		.mgmt_address     (mgmt_address),
		.mgmt_writedata   (mgmt_writedata),
		.cfg_ready        (cfg_ready)
	);

endmodule

/* verilog/pll_cfg_writer.sv */
`timescale 1ns/1ps

module pll_cfg_writer (
	input  logic                                      FPGA_CLK2_50,
	input  logic                                      resetd,
	input  logic                                      empty,
	input  hps_cfg_pkg::reconfig_write_t              pop_data,
	input  logic                                      mgmt_waitrequest,
	output logic                                      pop,
	output logic                                      mgmt_write,
	output logic [hps_cfg_pkg::reg_addr_width-1:0]    mgmt_address,
	output logic [hps_cfg_pkg::reg_data_width-1:0]    mgmt_writedata,
	output logic                                      cfg_ready
);

	logic load;

	// Idle master with something queued
	assign load = !mgmt_write && !empty;

	// Write accepted on this edge
	assign pop = mgmt_write && !mgmt_waitrequest;

	// ====================
	// Master handshake
	// ====================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			mgmt_write <= 1'b0;
			cfg_ready <= 1'b0;
		end else begin
			if (pop) begin
				mgmt_write <= 1'b0;
				// Start register kicks off the PLL
				if (mgmt_address == hps_cfg_pkg::reg_start)
					cfg_ready <= 1'b1;
			end else if (load) begin
				mgmt_write <= 1'b1;
			end
		end
	end

	// Address and data of the pending write
	always_ff @(posedge FPGA_CLK2_50) begin
		if (load) begin
			mgmt_address <= pop_data.addr;
			mgmt_writedata <= pop_data.data;
		end
	end

	// A stalled write keeps its request and payload
	assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		(mgmt_write && mgmt_waitrequest) |=>
			(mgmt_write && $stable(mgmt_address) && $stable(mgmt_writedata)))
		else $error("master write changed while waitrequest was high");

endmodule

/* verilog/reconfig_fifo.sv */
`timescale 1ns/1ps

module reconfig_fifo (
	input  logic                          FPGA_CLK2_50,
	input  logic                          resetd,
	input  logic                          push,
	input  hps_cfg_pkg::reconfig_write_t  push_data,
	input  logic                          pop,
	output hps_cfg_pkg::reconfig_write_t  pop_data,
	output logic                          full,
	output logic                          empty
);

	hps_cfg_pkg::reconfig_write_t         mem [hps_cfg_pkg::fifo_depth];
	logic [hps_cfg_pkg::fifo_ptr_width-1:0] wr_ptr;
	logic [hps_cfg_pkg::fifo_ptr_width-1:0] rd_ptr;
	logic [hps_cfg_pkg::fifo_ptr_width:0]   count;

	assign full = (count == hps_cfg_pkg::fifo_depth);
	assign empty = (count == '0);

	// Head entry
	assign pop_data = mem[rd_ptr];

	// ====================
	// Pointers and count
	// ====================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge FPGA_CLK2_50) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assert property (@(posedge FPGA_CLK2_50) disable iff (resetd) push |-> !full)
		else $error("push while queue full");

	assert property (@(posedge FPGA_CLK2_50) disable iff (resetd) pop |-> !empty)
		else $error("pop while queue empty");

endmodule

/* verilog/io_cmd_decoder.sv */
`timescale 1ns/1ps

module io_cmd_decoder (
	input  logic                                       FPGA_CLK2_50,
	input  logic                                       resetd,
	input  logic                                       io_clk,
	input  logic                                       io_uio,
	input  logic [hps_cfg_pkg::io_width-1:0]           io_din,
	input  logic                                       full,
	output logic                                       io_ack,
	output logic                                       push,
	output hps_cfg_pkg::reconfig_write_t               push_data,
	output logic                                       dvi_mode,
	output logic                                       audio_96k,
	output logic                                       ypbpr_en,
	output logic                                       csync,
	output logic [hps_cfg_pkg::timing_width-1:0]       width,
	output logic [hps_cfg_pkg::timing_width-1:0]       hfp,
	output logic [hps_cfg_pkg::timing_width-1:0]       hs,
	output logic [hps_cfg_pkg::timing_width-1:0]       hbp,
	output logic [hps_cfg_pkg::timing_width-1:0]       height,
	output logic [hps_cfg_pkg::timing_width-1:0]       vfp,
	output logic [hps_cfg_pkg::timing_width-1:0]       vs,
	output logic [hps_cfg_pkg::timing_width-1:0]       vbp
);

	logic                                    clk_meta;
	logic                                    clk_sync;
	logic                                    accept_ok;
	logic                                    strobe;
	logic                                    has_cmd;
	logic [7:0]                              cmd;
	logic [hps_cfg_pkg::cnt_width-1:0]       word_cnt;
	logic [hps_cfg_pkg::io_width-1:0]        cfg_word;
	logic                                    cfg_got;
	logic                                    custom_seen;
	logic                                    start_pend;
	logic [hps_cfg_pkg::reg_addr_width-1:0]  cust_addr;
	logic [hps_cfg_pkg::io_width-1:0]        cust_lo;

	// ====================
	// Host handshake
	// ====================

	// Hold off while the queue cannot take another entry
	assign accept_ok = !full && !push && !start_pend;
	assign strobe = (clk_sync != io_ack) && accept_ok;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			clk_meta <= 1'b0;
			clk_sync <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			clk_meta <= io_clk;
			clk_sync <= clk_meta;
			if (accept_ok)
				io_ack <= clk_sync;
		end
	end

	assign dvi_mode = cfg_word[hps_cfg_pkg::bit_dvi];
	assign audio_96k = cfg_word[hps_cfg_pkg::bit_audio_96k];
	assign ypbpr_en = cfg_word[hps_cfg_pkg::bit_ypbpr];
	assign csync = cfg_word[hps_cfg_pkg::bit_csync];

	// ====================
	// Command parser
	// ====================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd <= 8'h00;
			word_cnt <= '0;
			cfg_word <= '0;
			cfg_got <= 1'b0;
			custom_seen <= 1'b0;
			start_pend <= 1'b0;
			push <= 1'b0;
			width <= hps_cfg_pkg::def_width;
			hfp <= hps_cfg_pkg::def_hfp;
			hs <= hps_cfg_pkg::def_hs;
			hbp <= hps_cfg_pkg::def_hbp;
			height <= hps_cfg_pkg::def_height;
			vfp <= hps_cfg_pkg::def_vfp;
			vs <= hps_cfg_pkg::def_vs;
			vbp <= hps_cfg_pkg::def_vbp;
		end else begin
			push <= 1'b0;

			// Start write follows the default-mode write
			if (start_pend && !push && !full) begin
				push <= 1'b1;
				push_data.addr <= hps_cfg_pkg::reg_start;
				push_data.data <= '0;
				start_pend <= 1'b0;
			end

			if (!io_uio) begin
				has_cmd <= 1'b0;
			end else if (strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd <= io_din[7:0];
					word_cnt <= '0;
				end else if (cmd == hps_cfg_pkg::cmd_cfg) begin
					cfg_word <= io_din;
					if (!cfg_got) begin
						cfg_got <= 1'b1;
						push <= 1'b1;
						push_data.data <= '0;
						if (custom_seen) begin
							push_data.addr <= hps_cfg_pkg::reg_start;
						end else begin
							push_data.addr <= hps_cfg_pkg::reg_mode_default;
							start_pend <= 1'b1;
						end
					end
				end else if (cmd == hps_cfg_pkg::cmd_timing) begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt < hps_cfg_pkg::timing_count) begin
						case (word_cnt[2:0])
							3'd0: width <= io_din[hps_cfg_pkg::timing_width-1:0];
							3'd1: hfp <= io_din[hps_cfg_pkg::timing_width-1:0];
							3'd2: hs <= io_din[hps_cfg_pkg::timing_width-1:0];
							3'd3: hbp <= io_din[hps_cfg_pkg::timing_width-1:0];
							3'd4: height <= io_din[hps_cfg_pkg::timing_width-1:0];
							3'd5: vfp <= io_din[hps_cfg_pkg::timing_width-1:0];
							3'd6: vs <= io_din[hps_cfg_pkg::timing_width-1:0];
							default: vbp <= io_din[hps_cfg_pkg::timing_width-1:0];
						endcase
					end else begin
						// Triple: address, data low, data high
						case (word_cnt[1:0])
							2'd0: cust_addr <= io_din[hps_cfg_pkg::reg_addr_width-1:0];
							2'd1: cust_lo <= io_din;
							default: begin
								push <= 1'b1;
								push_data.addr <= cust_addr;
								push_data.data <= {io_din, cust_lo};
								custom_seen <= 1'b1;
								word_cnt <= hps_cfg_pkg::timing_count;
							end
						endcase
					end
				end
			end
		end
	end

	// Queue full is owned by the buffer
	assert property (@(posedge FPGA_CLK2_50) disable iff (resetd) push |-> !full)
		else $error("decoder pushed into a full queue");

endmodule

/* verilog/hps_cfg_pkg.sv */
package hps_cfg_pkg;

	// ====================
	// Host link
	// ====================
	localparam int io_width = 16;
	localparam int cnt_width = 4;

	localparam logic [7:0] cmd_cfg = 8'h01;
	localparam logic [7:0] cmd_timing = 8'h20;

	// Timing words ahead of the custom triples
	localparam logic [cnt_width-1:0] timing_count = 4'd8;

	// Flag positions in the config word
	localparam int bit_dvi = 7;
	localparam int bit_audio_96k = 6;
	localparam int bit_ypbpr = 5;
	localparam int bit_csync = 3;

	// ====================
	// Video timing
	// ====================
	localparam int timing_width = 12;

	// 1280x720@60 CEA
	localparam logic [timing_width-1:0] def_width = 12'd1280;
	localparam logic [timing_width-1:0] def_hfp = 12'd110;
	localparam logic [timing_width-1:0] def_hs = 12'd40;
	localparam logic [timing_width-1:0] def_hbp = 12'd220;
	localparam logic [timing_width-1:0] def_height = 12'd720;
	localparam logic [timing_width-1:0] def_vfp = 12'd5;
	localparam logic [timing_width-1:0] def_vs = 12'd5;
	localparam logic [timing_width-1:0] def_vbp = 12'd20;

	// ====================
	// PLL reconfiguration
	// ====================
	localparam int reg_addr_width = 6;
	localparam int reg_data_width = 32;
	localparam logic [reg_addr_width-1:0] reg_mode_default = 6'd31;
	localparam logic [reg_addr_width-1:0] reg_start = 6'd2;

	// Pending write queue, depth is a power of two
	localparam int fifo_ptr_width = 3;
	localparam logic [fifo_ptr_width:0] fifo_depth = 4'd8;

	typedef struct packed {
		logic [reg_addr_width-1:0] addr;
		logic [reg_data_width-1:0] data;
	} reconfig_write_t;

endpackage
